/* logic/ysyx_22050710_pkg.sv */
// shared widths, memory-op codes and stage bus structs, referenced by scoped name from the RTL
package ysyx_22050710_pkg;

  localparam int WORD_WD      = 64;
  localparam int GPR_ADDR_WD  = 5;
  localparam int CSR_ADDR_WD  = 12;
  localparam int MEM_OP_WD    = 3;
  localparam int SRAM_ADDR_WD = 16; // widest word index the sram request can carry

  typedef logic [WORD_WD-1:0]      word_t;
  typedef logic [GPR_ADDR_WD-1:0]  gpr_addr_t;
  typedef logic [CSR_ADDR_WD-1:0]  csr_addr_t;
  typedef logic [MEM_OP_WD-1:0]    mem_op_t;
  typedef logic [SRAM_ADDR_WD-1:0] sram_addr_t;
  typedef logic [7:0]              byte_mask_t;

  // load/store width codes, same as funct3
  localparam mem_op_t MEM_OP_B  = 3'b000;
  localparam mem_op_t MEM_OP_H  = 3'b001;
  localparam mem_op_t MEM_OP_W  = 3'b010;
  localparam mem_op_t MEM_OP_D  = 3'b011;
  localparam mem_op_t MEM_OP_BU = 3'b100;
  localparam mem_op_t MEM_OP_HU = 3'b101;
  localparam mem_op_t MEM_OP_WU = 3'b110;

  // execute -> memory
  typedef struct packed {
    gpr_addr_t gpr_rd;
    csr_addr_t csr_rd;
    logic      gpr_wen;
    logic      csr_wen;
    logic      mem_ren;
    logic      mem_wen;
    mem_op_t   mem_op;
    logic      csr_inst_sel; // gpr gets csr read data
    word_t     csrrdata;
    word_t     alu_result;   // also the memory address
    word_t     csr_result;
    word_t     store_data;
  } es_to_ms_bus_t;

  // memory -> write-back
  typedef struct packed {
    logic      gpr_wen;
    gpr_addr_t gpr_rd;
    word_t     gpr_result;
    logic      csr_wen;
    csr_addr_t csr_rd;
    word_t     csr_result;
  } ms_to_ws_bus_t;

  // data sram request
  typedef struct packed {
    logic       en;
    logic       wen;
    sram_addr_t addr;  // word index
    byte_mask_t wmask;
    word_t      wdata;
  } sram_req_t;

endpackage

/* logic/ysyx_22050710_lsu_store.sv */
// store path: builds the data sram request (word index, byte mask, lane-aligned data)
`timescale 1ns/1ns

module ysyx_22050710_lsu_store #(
  parameter int SRAM_AW = 8
) (
  input  logic                              i_valid, // transfer into the memory stage
  input  ysyx_22050710_pkg::es_to_ms_bus_t  i_bus,
  output ysyx_22050710_pkg::sram_req_t      o_req
);

  logic [2:0]                    offset;
  ysyx_22050710_pkg::byte_mask_t size_mask;

  assign offset = i_bus.alu_result[2:0];

  always_comb begin
    case (i_bus.mem_op)
      ysyx_22050710_pkg::MEM_OP_B: size_mask = 8'h01;
      ysyx_22050710_pkg::MEM_OP_H: size_mask = 8'h03;
      ysyx_22050710_pkg::MEM_OP_W: size_mask = 8'h0f;
      ysyx_22050710_pkg::MEM_OP_D: size_mask = 8'hff;
      default:                     size_mask = 8'h00;
    endcase
  end

  always_comb begin
    o_req.en    = i_valid && (i_bus.mem_ren || i_bus.mem_wen);
    o_req.wen   = i_valid && i_bus.mem_wen;
    o_req.addr  = ysyx_22050710_pkg::sram_addr_t'(i_bus.alu_result[SRAM_AW+2:3]);
    o_req.wmask = size_mask << offset;
    o_req.wdata = i_bus.store_data << {offset, 3'b000}; // move into byte lanes
  end

endmodule

/* logic/ysyx_22050710_data_sram.sv */
// single-port data sram, byte-masked write and registered read, one access per accepted request
`timescale 1ns/1ns

module ysyx_22050710_data_sram #(
  parameter int SRAM_AW = 8
) (
  input  logic                          i_clk,
  input  ysyx_22050710_pkg::sram_req_t  i_req,
  output ysyx_22050710_pkg::word_t      o_rdata
);

  localparam int DEPTH = 1 << SRAM_AW;

  ysyx_22050710_pkg::word_t mem [DEPTH] = '{default: '0};
  logic [SRAM_AW-1:0]       word_idx;

  assign word_idx = i_req.addr[SRAM_AW-1:0];

  // read data only moves on an accepted request, so it holds while the stage is stalled
  always_ff @(posedge i_clk) begin
    if (i_req.en) begin
      if (i_req.wen) begin
        for (int b = 0; b < 8; b++) begin
          if (i_req.wmask[b]) begin
            mem[word_idx][b*8 +: 8] <= i_req.wdata[b*8 +: 8];
          end
        end
      end
      o_rdata <= mem[word_idx]; // old data on a write
    end
  end

endmodule

/* logic/ysyx_22050710_lsu_load.sv */
// load path: picks the addressed byte/half/word out of the sram word and extends it
`timescale 1ns/1ns

module ysyx_22050710_lsu_load (
  input  logic [2:0]                  i_raddr_align, // low address bits
  input  ysyx_22050710_pkg::word_t    i_data_sram_rdata,
  input  ysyx_22050710_pkg::mem_op_t  i_mem_op,
  output ysyx_22050710_pkg::word_t    o_rdata
);

  ysyx_22050710_pkg::word_t shifted;

  assign shifted = i_data_sram_rdata >> {i_raddr_align, 3'b000};

  always_comb begin
    case (i_mem_op)
      ysyx_22050710_pkg::MEM_OP_B: begin
        o_rdata = {{56{shifted[7]}}, shifted[7:0]};
      end
      ysyx_22050710_pkg::MEM_OP_H: begin
        o_rdata = {{48{shifted[15]}}, shifted[15:0]};
      end
      ysyx_22050710_pkg::MEM_OP_W: begin
        o_rdata = {{32{shifted[31]}}, shifted[31:0]};
      end
      ysyx_22050710_pkg::MEM_OP_BU: begin
        o_rdata = {56'd0, shifted[7:0]};
      end
      ysyx_22050710_pkg::MEM_OP_HU: begin
        o_rdata = {48'd0, shifted[15:0]};
      end
      ysyx_22050710_pkg::MEM_OP_WU: begin
        o_rdata = {32'd0, shifted[31:0]};
      end
      default: begin
        o_rdata = shifted; // ld
      end
    endcase
  end

endmodule

/* logic/ysyx_22050710_mem_stage.sv */
// memory stage: stage register with valid/allowin handshake, load extract and gpr result select
`timescale 1ns/1ns

module ysyx_22050710_mem_stage (
  input  logic                              i_clk,
  input  logic                              i_rst,
  // allowin
  input  logic                              i_ws_allowin,
  output logic                              o_ms_allowin,
  // from es
  input  logic                              i_es_to_ms_valid,
  input  ysyx_22050710_pkg::es_to_ms_bus_t  i_es_to_ms_bus,
  // to ws
  output logic                              o_ms_to_ws_valid,
  output ysyx_22050710_pkg::ms_to_ws_bus_t  o_ms_to_ws_bus,
  // from data sram
  input  ysyx_22050710_pkg::word_t          i_data_sram_rdata,
  // pending dest for decode stall
  output ysyx_22050710_pkg::gpr_addr_t      o_ms_to_ds_gpr_rd,
  output ysyx_22050710_pkg::csr_addr_t      o_ms_to_ds_csr_rd
);

  logic                             ms_valid;
  logic                             ms_ready_go;
  ysyx_22050710_pkg::es_to_ms_bus_t ms_bus;
  ysyx_22050710_pkg::word_t         mem_rdata;
  ysyx_22050710_pkg::word_t         gpr_result;

  assign ms_ready_go      = 1'b1; // sram answers in one cycle
  assign o_ms_allowin     = !ms_valid || (ms_ready_go && i_ws_allowin);
  assign o_ms_to_ws_valid = ms_valid && ms_ready_go;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ms_valid <= 1'b0;
    end else if (o_ms_allowin) begin
      ms_valid <= i_es_to_ms_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_es_to_ms_valid && o_ms_allowin) begin
      ms_bus <= i_es_to_ms_bus;
    end
  end

  ysyx_22050710_lsu_load u_lsu_load (
    .i_raddr_align     (ms_bus.alu_result[2:0]),
    .i_data_sram_rdata (i_data_sram_rdata),
    .i_mem_op          (ms_bus.mem_op),
    .o_rdata           (mem_rdata)
  );

  assign gpr_result = ms_bus.mem_ren      ? mem_rdata
                    : ms_bus.csr_inst_sel ? ms_bus.csrrdata
                    :                       ms_bus.alu_result;

  always_comb begin
    o_ms_to_ws_bus.gpr_wen    = ms_bus.gpr_wen;
    o_ms_to_ws_bus.gpr_rd     = ms_bus.gpr_rd;
    o_ms_to_ws_bus.gpr_result = gpr_result;
    o_ms_to_ws_bus.csr_wen    = ms_bus.csr_wen;
    o_ms_to_ws_bus.csr_rd     = ms_bus.csr_rd;
    o_ms_to_ws_bus.csr_result = ms_bus.csr_result;
  end

  assign o_ms_to_ds_gpr_rd = (ms_valid && ms_bus.gpr_wen) ? ms_bus.gpr_rd : '0;
  assign o_ms_to_ds_csr_rd = (ms_valid && ms_bus.csr_wen) ? ms_bus.csr_rd : '0;

endmodule

/* logic/ysyx_22050710_wb_stage.sv */
// write-back stage: holds the retiring instruction until commit allows it, drives gpr/csr writes
`timescale 1ns/1ns

module ysyx_22050710_wb_stage (
  input  logic                              i_clk,
  input  logic                              i_rst,
  input  logic                              i_commit_stall, // hold from commit side
  // from ms
  input  logic                              i_ms_to_ws_valid,
  input  ysyx_22050710_pkg::ms_to_ws_bus_t  i_ms_to_ws_bus,
  output logic                              o_ws_allowin,
  // gpr write
  output logic                              o_gpr_wen,
  output ysyx_22050710_pkg::gpr_addr_t      o_gpr_waddr,
  output ysyx_22050710_pkg::word_t          o_gpr_wdata,
  // csr write
  output logic                              o_csr_wen,
  output ysyx_22050710_pkg::csr_addr_t      o_csr_waddr,
  output ysyx_22050710_pkg::word_t          o_csr_wdata,
  output logic                              o_retire_valid,
  output ysyx_22050710_pkg::gpr_addr_t      o_ws_to_ds_gpr_rd
);

  logic                             ws_valid;
  logic                             ws_ready_go;
  ysyx_22050710_pkg::ms_to_ws_bus_t ws_bus;

  assign ws_ready_go  = !i_commit_stall;
  assign o_ws_allowin = !ws_valid || ws_ready_go;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ws_valid <= 1'b0;
    end else if (o_ws_allowin) begin
      ws_valid <= i_ms_to_ws_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_ms_to_ws_valid && o_ws_allowin) begin
      ws_bus <= i_ms_to_ws_bus;
    end
  end

  // fires once, in the cycle the instruction leaves
  assign o_retire_valid = ws_valid && ws_ready_go;

  assign o_gpr_wen   = o_retire_valid && ws_bus.gpr_wen;
  assign o_gpr_waddr = ws_bus.gpr_rd;
  assign o_gpr_wdata = ws_bus.gpr_result;
  assign o_csr_wen   = o_retire_valid && ws_bus.csr_wen;
  assign o_csr_waddr = ws_bus.csr_rd;
  assign o_csr_wdata = ws_bus.csr_result;

  assign o_ws_to_ds_gpr_rd = (ws_valid && ws_bus.gpr_wen) ? ws_bus.gpr_rd : '0;

endmodule

/* logic/ysyx_22050710_regfile.sv */
// integer register file, 32 x 64, one sync write port and two async read ports, x0 hardwired
`timescale 1ns/1ns

module ysyx_22050710_regfile (
  input  logic                          i_clk,
  input  logic                          i_wen,
  input  ysyx_22050710_pkg::gpr_addr_t  i_waddr,
  input  ysyx_22050710_pkg::word_t      i_wdata,
  input  ysyx_22050710_pkg::gpr_addr_t  i_raddr1,
  input  ysyx_22050710_pkg::gpr_addr_t  i_raddr2,
  output ysyx_22050710_pkg::word_t      o_rdata1,
  output ysyx_22050710_pkg::word_t      o_rdata2
);

  ysyx_22050710_pkg::word_t regs [32];

  always_ff @(posedge i_clk) begin
    if (i_wen && (i_waddr != '0)) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

/* logic/ysyx_22050710_lsu_wb_top.sv */
// back-end top: store path, data sram, memory and write-back stages, register file
`timescale 1ns/1ns

module ysyx_22050710_lsu_wb_top #(
  parameter int SRAM_AW = 8
) (
  input  logic                              i_clk,
  input  logic                              i_rst,
  // from execute
  input  logic                              i_es_valid,
  input  ysyx_22050710_pkg::es_to_ms_bus_t  i_es_bus,
  output logic                              o_es_allowin,
  input  logic                              i_commit_stall,
  // gpr read ports
  input  ysyx_22050710_pkg::gpr_addr_t      i_raddr1,
  input  ysyx_22050710_pkg::gpr_addr_t      i_raddr2,
  output ysyx_22050710_pkg::word_t          o_rdata1,
  output ysyx_22050710_pkg::word_t          o_rdata2,
  // hazard dests
  output ysyx_22050710_pkg::gpr_addr_t      o_ms_gpr_rd,
  output ysyx_22050710_pkg::csr_addr_t      o_ms_csr_rd,
  output ysyx_22050710_pkg::gpr_addr_t      o_ws_gpr_rd,
  // retire trace
  output logic                              o_retire_valid,
  output logic                              o_retire_gpr_wen,
  output ysyx_22050710_pkg::gpr_addr_t      o_retire_rd,
  output ysyx_22050710_pkg::word_t          o_retire_wdata,
  // csr write port
  output logic                              o_csr_wen,
  output ysyx_22050710_pkg::csr_addr_t      o_csr_waddr,
  output ysyx_22050710_pkg::word_t          o_csr_wdata
);

  ysyx_22050710_pkg::sram_req_t     sram_req;
  ysyx_22050710_pkg::word_t         sram_rdata;
  logic                             ms_to_ws_valid;
  ysyx_22050710_pkg::ms_to_ws_bus_t ms_to_ws_bus;
  logic                             ws_allowin;

  ysyx_22050710_lsu_store #(
    .SRAM_AW (SRAM_AW)
  ) u_lsu_store (
    .i_valid (i_es_valid && o_es_allowin), // same edge the memory stage captures
    .i_bus   (i_es_bus),
    .o_req   (sram_req)
  );

  ysyx_22050710_data_sram #(
    .SRAM_AW (SRAM_AW)
  ) u_data_sram (
    .i_clk   (i_clk),
    .i_req   (sram_req),
    .o_rdata (sram_rdata)
  );

  ysyx_22050710_mem_stage u_mem_stage (
    .i_clk             (i_clk),
    .i_rst             (i_rst),
    .i_ws_allowin      (ws_allowin),
    .o_ms_allowin      (o_es_allowin),
    .i_es_to_ms_valid  (i_es_valid),
    .i_es_to_ms_bus    (i_es_bus),
    .o_ms_to_ws_valid  (ms_to_ws_valid),
    .o_ms_to_ws_bus    (ms_to_ws_bus),
    .i_data_sram_rdata (sram_rdata),
    .o_ms_to_ds_gpr_rd (o_ms_gpr_rd),
    .o_ms_to_ds_csr_rd (o_ms_csr_rd)
  );

  ysyx_22050710_wb_stage u_wb_stage (
    .i_clk             (i_clk),
    .i_rst             (i_rst),
    .i_commit_stall    (i_commit_stall),
    .i_ms_to_ws_valid  (ms_to_ws_valid),
    .i_ms_to_ws_bus    (ms_to_ws_bus),
    .o_ws_allowin      (ws_allowin),
    .o_gpr_wen         (o_retire_gpr_wen),
    .o_gpr_waddr       (o_retire_rd),
    .o_gpr_wdata       (o_retire_wdata),
    .o_csr_wen         (o_csr_wen),
    .o_csr_waddr       (o_csr_waddr),
    .o_csr_wdata       (o_csr_wdata),
    .o_retire_valid    (o_retire_valid),
    .o_ws_to_ds_gpr_rd (o_ws_gpr_rd)
  );

  // retire trace doubles as the gpr write port
  ysyx_22050710_regfile u_regfile (
    .i_clk    (i_clk),
    .i_wen    (o_retire_gpr_wen),
    .i_waddr  (o_retire_rd),
    .i_wdata  (o_retire_wdata),
    .i_raddr1 (i_raddr1),
    .i_raddr2 (i_raddr2),
    .o_rdata1 (o_rdata1),
    .o_rdata2 (o_rdata2)
  );

endmodule

/* tb/ysyx_22050710_mem_stage_sva.sv */
// handshake assertions for the memory stage, bound into every memory stage instance
`timescale 1ns/1ns

module ysyx_22050710_mem_stage_sva (
  input logic                             i_clk,
  input logic                             i_rst,
  input logic                             i_valid,      // memory stage output valid
  input logic                             i_ws_allowin,
  input ysyx_22050710_pkg::ms_to_ws_bus_t i_bus
);

  // held output keeps its valid
  assert property (@(posedge i_clk) disable iff (i_rst)
    (i_valid && !i_ws_allowin) |=> i_valid)
    else $error("memory stage valid dropped while write-back was not accepting");

  // and its payload
  assert property (@(posedge i_clk) disable iff (i_rst)
    (i_valid && !i_ws_allowin) |=> $stable(i_bus))
    else $error("memory stage bus changed while held");

  assert property (@(posedge i_clk) i_rst |=> !i_valid)
    else $error("memory stage valid high after a reset cycle");

endmodule

bind ysyx_22050710_mem_stage ysyx_22050710_mem_stage_sva u_mem_stage_sva (
  .i_clk        (i_clk),
  .i_rst        (i_rst),
  .i_valid      (o_ms_to_ws_valid),
  .i_ws_allowin (i_ws_allowin),
  .i_bus        (o_ms_to_ws_bus)
);

/* tb/tb_top.sv */
// drives random instructions into the back end and checks them against memory and register models
`timescale 1ns/1ns

module tb_top;

  localparam int N_INSTR     = 240;                      // 48+48+48+96 issued
  localparam int WATCHDOG_NS = N_INSTR * 40 * 40 + 8000; // 40 cycles per instruction plus readback

  logic                             clk = 1'b0;
  logic                             rst;
  logic                             es_valid;
  ysyx_22050710_pkg::es_to_ms_bus_t es_bus;
  logic                             es_allowin;
  logic                             commit_stall;
  ysyx_22050710_pkg::gpr_addr_t     raddr1;
  ysyx_22050710_pkg::gpr_addr_t     raddr2;
  ysyx_22050710_pkg::word_t         rdata1;
  ysyx_22050710_pkg::word_t         rdata2;
  ysyx_22050710_pkg::gpr_addr_t     ms_gpr_rd;
  ysyx_22050710_pkg::csr_addr_t     ms_csr_rd;
  ysyx_22050710_pkg::gpr_addr_t     ws_gpr_rd;
  logic                             retire_valid;
  logic                             retire_gpr_wen;
  ysyx_22050710_pkg::gpr_addr_t     retire_rd;
  ysyx_22050710_pkg::word_t         retire_wdata;
  logic                             csr_wen;
  ysyx_22050710_pkg::csr_addr_t     csr_waddr;
  ysyx_22050710_pkg::word_t         csr_wdata;

  integer seed        = 32'h211e;
  int     pass_cnt    = 0;
  int     fail_cnt    = 0;
  int     hazard_errs = 0;
  int     errs;
  logic   stall_en    = 1'b0;
  logic   xfer_now    = 1'b0; // transfer happens at the coming rising edge

  logic [7:0]                       mem_model [512] = '{default: 8'h00};
  ysyx_22050710_pkg::word_t         regs_model [32] = '{default: '0};
  bit                               reg_written [32] = '{default: 1'b0};
  ysyx_22050710_pkg::ms_to_ws_bus_t exp_q [$];      // accepted and not yet retired

  ysyx_22050710_lsu_wb_top #(
    .SRAM_AW (6)
  ) ysyx_22050710_lsu_wb_top_i (
    .i_clk (clk), .i_rst (rst),
    .i_es_valid (es_valid), .i_es_bus (es_bus), .o_es_allowin (es_allowin),
    .i_commit_stall (commit_stall),
    .i_raddr1 (raddr1), .i_raddr2 (raddr2), .o_rdata1 (rdata1), .o_rdata2 (rdata2),
    .o_ms_gpr_rd (ms_gpr_rd), .o_ms_csr_rd (ms_csr_rd), .o_ws_gpr_rd (ws_gpr_rd),
    .o_retire_valid (retire_valid), .o_retire_gpr_wen (retire_gpr_wen),
    .o_retire_rd (retire_rd), .o_retire_wdata (retire_wdata),
    .o_csr_wen (csr_wen), .o_csr_waddr (csr_waddr), .o_csr_wdata (csr_wdata)
  );

  always #20 clk = ~clk;

  task automatic compare_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      fail_cnt++;
    end else begin
      pass_cnt++;
    end
  endtask

  function automatic ysyx_22050710_pkg::word_t rnd64();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = $random(seed);
    lo = $random(seed);
    return {hi, lo};
  endfunction

  // kind 0 store, 1 load, 2 alu/csr, 3 any of them
  function automatic ysyx_22050710_pkg::es_to_ms_bus_t random_instr(input int kind);
    ysyx_22050710_pkg::es_to_ms_bus_t b;
    ysyx_22050710_pkg::word_t         r;
    logic [6:0]                       addr;
    int                               k;
    r = rnd64();
    k = (kind == 3) ? int'(r[63:62]) % 3 : kind;
    b.gpr_rd       = r[4:0];
    b.csr_rd       = r[16:5];
    b.gpr_wen      = r[17];
    b.csr_wen      = r[18];
    b.csr_inst_sel = r[19];
    b.mem_op       = r[22:20];
    b.mem_ren      = 1'b0;
    b.mem_wen      = 1'b0;
    addr           = r[29:23]; // 128-byte window so loads hit earlier stores
    b.csrrdata     = rnd64();
    b.alu_result   = rnd64();
    b.csr_result   = rnd64();
    b.store_data   = rnd64();
    if (k == 0) begin
      b.mem_wen   = 1'b1;
      b.gpr_wen   = 1'b0;
      b.csr_wen   = 1'b0;
      b.mem_op[2] = 1'b0;
    end else if (k == 1) begin
      b.mem_ren = 1'b1;
      b.gpr_wen = 1'b1;
      b.csr_wen = 1'b0;
      if (b.mem_op == 3'b111) b.mem_op = ysyx_22050710_pkg::MEM_OP_D;
    end
    if (k < 2) begin
      addr         = (addr >> b.mem_op[1:0]) << b.mem_op[1:0]; // natural alignment
      b.alu_result = {57'd0, addr};
    end
    return b;
  endfunction

  // little-endian bytes from the model extended by op
  function automatic ysyx_22050710_pkg::word_t load_value(input logic [8:0] addr,
                                                          input ysyx_22050710_pkg::mem_op_t op);
    ysyx_22050710_pkg::word_t v;
    logic [8:0]               idx;
    v = '0;
    for (int i = (1 << op[1:0]) - 1; i >= 0; i--) begin
      idx = addr + 9'(i);
      v   = {v[55:0], mem_model[idx]};
    end
    case (op)
      ysyx_22050710_pkg::MEM_OP_B: v = {{56{v[7]}}, v[7:0]};
      ysyx_22050710_pkg::MEM_OP_H: v = {{48{v[15]}}, v[15:0]};
      ysyx_22050710_pkg::MEM_OP_W: v = {{32{v[31]}}, v[31:0]};
      default: ; // zero-extended already
    endcase
    return v;
  endfunction

  task automatic push_expected(input ysyx_22050710_pkg::es_to_ms_bus_t b);
    ysyx_22050710_pkg::ms_to_ws_bus_t e;
    ysyx_22050710_pkg::word_t         sd;
    logic [8:0]                       idx;
    idx = b.alu_result[8:0];
    sd  = b.store_data;
    if (b.mem_wen) begin
      for (int i = 0; i < (1 << b.mem_op[1:0]); i++) begin
        mem_model[idx] = sd[7:0];
        sd  = sd >> 8;
        idx = idx + 9'd1;
      end
    end
    e.gpr_wen    = b.gpr_wen;
    e.gpr_rd     = b.gpr_rd;
    e.csr_wen    = b.csr_wen;
    e.csr_rd     = b.csr_rd;
    e.csr_result = b.csr_result;
    if (b.mem_ren) e.gpr_result = load_value(b.alu_result[8:0], b.mem_op);
    else if (b.csr_inst_sel) e.gpr_result = b.csrrdata;
    else e.gpr_result = b.alu_result;
    exp_q.push_back(e);
  endtask

  task automatic check_retire(input ysyx_22050710_pkg::ms_to_ws_bus_t e);
    compare_value("o_retire_gpr_wen", 64'(e.gpr_wen), 64'(retire_gpr_wen));
    compare_value("o_retire_rd", 64'(e.gpr_rd), 64'(retire_rd));
    compare_value("o_retire_wdata", e.gpr_result, retire_wdata);
    compare_value("o_csr_wen", 64'(e.csr_wen), 64'(csr_wen));
    if (e.csr_wen) begin
      compare_value("o_csr_waddr", 64'(e.csr_rd), 64'(csr_waddr));
      compare_value("o_csr_wdata", e.csr_result, csr_wdata);
    end
    if (e.gpr_wen && e.gpr_rd != '0) begin
      regs_model[e.gpr_rd]  = e.gpr_result;
      reg_written[e.gpr_rd] = 1'b1;
    end
  endtask

  // csr selects the csr destination, otherwise the gpr one
  function automatic bit in_flight(input bit csr, input logic [11:0] rd);
    foreach (exp_q[i]) begin
      if (csr ? (exp_q[i].csr_wen && exp_q[i].csr_rd == rd)
              : (exp_q[i].gpr_wen && 12'(exp_q[i].gpr_rd) == rd)) return 1'b1;
    end
    return 1'b0;
  endfunction

  task automatic check_hazard(input string name, input bit csr, input logic [11:0] rd);
    if (rd != '0 && !in_flight(csr, rd)) begin
      $display("%s shows register %0d at %0t ns but no instruction in flight writes it",
               name, rd, $time);
      fail_cnt++;
      hazard_errs++;
    end
  endtask

  // outputs settle by the falling edge
  always @(negedge clk) begin
    xfer_now = 1'b0;
    if (!rst) begin
      check_hazard("o_ms_gpr_rd", 1'b0, 12'(ms_gpr_rd));
      check_hazard("o_ms_csr_rd", 1'b1, ms_csr_rd);
      check_hazard("o_ws_gpr_rd", 1'b0, 12'(ws_gpr_rd));
      if (retire_valid && exp_q.size() == 0) begin
        $display("instruction retired at %0t ns with nothing outstanding", $time);
        fail_cnt++;
      end else if (retire_valid) begin
        check_retire(exp_q.pop_front());
      end else if (retire_gpr_wen || csr_wen) begin
        $display("register write enable high without a retire at %0t ns", $time);
        fail_cnt++;
      end
      if (es_valid && es_allowin) begin
        push_expected(es_bus);
        xfer_now = 1'b1;
      end
    end
  end

  always @(posedge clk) begin
    logic [31:0] r;
    r = $random(seed);
    commit_stall <= stall_en && (r[1:0] == 2'b00);
  end

  // called at a rising edge and returns at the transfer edge
  task automatic issue(input ysyx_22050710_pkg::es_to_ms_bus_t b);
    es_valid <= 1'b1;
    es_bus   <= b;
    do @(posedge clk); while (!xfer_now);
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) @(posedge clk);
    @(negedge clk);
    compare_value("o_ms_gpr_rd", 64'd0, 64'(ms_gpr_rd));
    compare_value("o_ms_csr_rd", 64'd0, 64'(ms_csr_rd));
    compare_value("o_ws_gpr_rd", 64'd0, 64'(ws_gpr_rd));
  endtask

  task automatic run_batch(input int kind, input int count, input bit stalls);
    logic [31:0] r;
    @(posedge clk);
    stall_en = stalls;
    for (int i = 0; i < count; i++) begin
      issue(random_instr(kind));
      r = $random(seed);
      if (stalls && r[2:0] == 3'd0) begin // bubble from execute
        es_valid <= 1'b0;
        @(posedge clk);
      end
    end
    es_valid <= 1'b0;
    stall_en = 1'b0;
    wait_drain();
  endtask

  // registers never written hold no known value, x0 is always known
  task automatic check_regfile();
    ysyx_22050710_pkg::gpr_addr_t a;
    ysyx_22050710_pkg::gpr_addr_t b;
    for (int i = 0; i < 32; i++) begin
      a = 5'(i);
      b = ~a;
      @(posedge clk);
      raddr1 <= a;
      raddr2 <= b;
      @(negedge clk);
      if (reg_written[a] || a == '0) compare_value("o_rdata1", regs_model[a], rdata1);
      if (reg_written[b] || b == '0) compare_value("o_rdata2", regs_model[b], rdata2);
    end
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the pipeline stopped retiring instructions");
    $display("sim failed");
    $finish;
  end

  initial begin
    rst          = 1'b1;
    es_valid     = 1'b0;
    es_bus       = '0;
    commit_stall = 1'b0;
    raddr1       = '0;
    raddr2       = '0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    errs = fail_cnt;
    run_batch(0, 48, 1'b0);
    run_batch(1, 48, 1'b0);
    $display("test store_load: %0d errors", fail_cnt - errs);
    errs = fail_cnt;
    run_batch(2, 48, 1'b0);
    $display("test result_select: %0d errors", fail_cnt - errs);
    errs = fail_cnt;
    run_batch(3, 96, 1'b1);
    $display("test stall_order: %0d errors", fail_cnt - errs);
    errs = fail_cnt;
    check_regfile();
    $display("test regfile: %0d errors", fail_cnt - errs);
    $display("test hazard: %0d errors", hazard_errs);
    $display("checks passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* tb.f */
logic/ysyx_22050710_pkg.sv
logic/ysyx_22050710_lsu_store.sv
logic/ysyx_22050710_data_sram.sv
logic/ysyx_22050710_lsu_load.sv
logic/ysyx_22050710_mem_stage.sv
logic/ysyx_22050710_wb_stage.sv
logic/ysyx_22050710_regfile.sv
logic/ysyx_22050710_lsu_wb_top.sv
tb/ysyx_22050710_mem_stage_sva.sv
tb/tb_top.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the back-end simulation with Verilator, exit status follows the result
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_top -f tb.f --Mdir obj_dir -o sim

out="$(./obj_dir/sim)"
echo "$out"
echo "$out" | grep -q "^sim passed$"
